// ==== common/game_link_pkg.sv ====
package game_link_pkg;

    // serial bit timing, kept short for simulation.
    localparam int CLKS_PER_BIT = 16;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    // receive buffer geometry.
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // bytes sent by the opponent console.
    typedef enum logic [7:0] {
        MSG_LOST  = 8'h4C,
        MSG_READY = 8'h52,
        MSG_HIT   = 8'h48
    } msg_code_e;

    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } uart_state_e;

    // DEC_IDLE doubles as "no event" wherever an event kind is needed.
    typedef enum logic [1:0] {
        DEC_IDLE    = 2'd0,
        DEC_VICTORY = 2'd1,
        DEC_READY   = 2'd2,
        DEC_HIT     = 2'd3
    } decoder_state_e;

endpackage

// ==== hw/uart_rx/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx
    import game_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       frame_error
);

    logic rxd_meta;
    logic rxd_sync;
    logic rxd_prev;
    logic rxd_fall;

    uart_state_e          state;
    uart_state_e          state_nxt;
    logic [BIT_CNT_W-1:0] cnt;
    logic [BIT_CNT_W-1:0] cnt_nxt;
    logic [2:0]           bit_idx;
    logic [2:0]           bit_idx_nxt;
    logic [7:0]           shift_nxt;
    logic                 rx_valid_nxt;
    logic                 frame_error_nxt;

    // two-flop synchronizer that starts at the idle line level.
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign rxd_fall = rxd_prev & ~rxd_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= RX_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            state       <= state_nxt;
            cnt         <= cnt_nxt;
            bit_idx     <= bit_idx_nxt;
            rx_valid    <= rx_valid_nxt;
            frame_error <= frame_error_nxt;
        end
    end

    // received bits shift in from the top.
    always_ff @(posedge clk) begin
        rx_data <= shift_nxt;
    end

    always_comb begin
        state_nxt       = state;
        cnt_nxt         = cnt + 1'b1;
        bit_idx_nxt     = bit_idx;
        shift_nxt       = rx_data;
        rx_valid_nxt    = 1'b0;
        frame_error_nxt = 1'b0;

        case (state)
            RX_IDLE: begin
                cnt_nxt = '0;
                if (rxd_fall) begin
                    state_nxt = RX_START;
                end
            end

            // half a bit in, confirm the start bit is still low.
            RX_START: begin
                if (cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                    cnt_nxt     = '0;
                    bit_idx_nxt = '0;
                    state_nxt   = rxd_sync ? RX_IDLE : RX_DATA;
                end
            end

            RX_DATA: begin
                if (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                    cnt_nxt     = '0;
                    shift_nxt   = {rxd_sync, rx_data[7:1]};
                    bit_idx_nxt = bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state_nxt = RX_STOP;
                    end
                end
            end

            RX_STOP: begin
                if (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                    cnt_nxt         = '0;
                    state_nxt       = RX_IDLE;
                    rx_valid_nxt    = rxd_sync;
                    frame_error_nxt = ~rxd_sync;
                end
            end

            default: begin
                state_nxt = RX_IDLE;
            end
        endcase
    end

endmodule

// ==== hw/char_fifo/char_fifo.sv ====
`timescale 1ns/1ns

module char_fifo
    import game_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       pop,
    output logic [7:0] rd_data,
    output logic       empty,
    output logic       rx_overflow
);

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               do_wr;
    logic               do_rd;

    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en & ~full;
    assign do_rd = pop & ~empty;

    // show-ahead, oldest byte always on the output.
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            rx_overflow <= 1'b0;
        end else begin
            rx_overflow <= wr_en & full;
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the decoder must only pop what it can see.
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) !(pop && empty)
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) count <= (FIFO_AW + 1)'(FIFO_DEPTH)
    );

endmodule

// ==== hw/opponent_msg_decoder/opponent_msg_decoder.sv ====
`timescale 1ns/1ns

module opponent_msg_decoder
    import game_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       multiplayer,
    input  logic [7:0] rd_data,
    input  logic       empty,
    output logic       pop,
    output logic       victory,
    output logic       opponent_ready,
    output logic       opponent_hit
);

    decoder_state_e state;
    decoder_state_e state_nxt;
    logic           victory_nxt;
    logic           opponent_ready_nxt;
    logic           opponent_hit_nxt;

    // take a byte whenever idle, even in single-player mode.
    assign pop = (state == DEC_IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= DEC_IDLE;
            victory        <= 1'b0;
            opponent_ready <= 1'b0;
            opponent_hit   <= 1'b0;
        end else begin
            state          <= state_nxt;
            victory        <= victory_nxt;
            opponent_ready <= opponent_ready_nxt;
            opponent_hit   <= opponent_hit_nxt;
        end
    end

    always_comb begin
        state_nxt          = state;
        victory_nxt        = 1'b0;
        opponent_ready_nxt = 1'b0;
        opponent_hit_nxt   = 1'b0;

        case (state)
            DEC_IDLE: begin
                // bytes popped outside multiplayer are simply dropped.
                if (pop && multiplayer) begin
                    case (rd_data)
                        MSG_LOST:  state_nxt = DEC_VICTORY;
                        MSG_READY: state_nxt = DEC_READY;
                        MSG_HIT:   state_nxt = DEC_HIT;
                        default:   state_nxt = DEC_IDLE;
                    endcase
                end
            end

            DEC_VICTORY: begin
                victory_nxt = 1'b1;
                state_nxt   = DEC_IDLE;
            end

            DEC_READY: begin
                opponent_ready_nxt = 1'b1;
                state_nxt          = DEC_IDLE;
            end

            DEC_HIT: begin
                opponent_hit_nxt = 1'b1;
                state_nxt        = DEC_IDLE;
            end

            default: begin
                state_nxt = DEC_IDLE;
            end
        endcase
    end

    // one byte, one event at most.
    a_single_event: assert property (
        @(posedge clk) disable iff (rst)
            $onehot0({victory, opponent_ready, opponent_hit})
    );

endmodule

// ==== hw/link_rx_top.sv ====
`timescale 1ns/1ns

module link_rx_top (
    input  logic clk,
    input  logic rst,
    input  logic rxd,
    input  logic multiplayer,
    output logic victory,
    output logic opponent_ready,
    output logic opponent_hit,
    output logic frame_error,
    output logic rx_overflow
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] fifo_rd_data;
    logic       fifo_empty;
    logic       fifo_pop;

    uart_rx u_uart_rx (
        .clk         (clk),
        .rst         (rst),
        .rxd         (rxd),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .frame_error (frame_error)
    );

    char_fifo u_char_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (rx_valid),
        .wr_data     (rx_data),
        .pop         (fifo_pop),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty),
        .rx_overflow (rx_overflow)
    );

    opponent_msg_decoder u_decoder (
        .clk            (clk),
        .rst            (rst),
        .multiplayer    (multiplayer),
        .rd_data        (fifo_rd_data),
        .empty          (fifo_empty),
        .pop            (fifo_pop),
        .victory        (victory),
        .opponent_ready (opponent_ready),
        .opponent_hit   (opponent_hit)
    );

endmodule

// ==== verification/link_rx_tb.sv ====
`timescale 1ns/1ns

module link_rx_tb
    import game_link_pkg::*;
();

    localparam int EVENT_TIMEOUT = 40 * CLKS_PER_BIT;

    logic clk;
    logic rst;
    logic rxd;
    logic multiplayer;
    logic victory;
    logic opponent_ready;
    logic opponent_hit;
    logic frame_error;
    logic rx_overflow;

    decoder_state_e exp_q[$];
    decoder_state_e obs_q[$];
    int errors;
    int fe_count;
    int ovf_count;
    int tests_passed;
    int tests_failed;
    int test_num;
    int errors_at_start;

    link_rx_top DUT (
        .clk            (clk),
        .rst            (rst),
        .rxd            (rxd),
        .multiplayer    (multiplayer),
        .victory        (victory),
        .opponent_ready (opponent_ready),
        .opponent_hit   (opponent_hit),
        .frame_error    (frame_error),
        .rx_overflow    (rx_overflow)
    );

    always #5 clk = ~clk;

    // what the opponent byte should turn into.
    function automatic decoder_state_e expected_event(input logic [7:0] b, input logic mp);
        if (!mp) begin
            return DEC_IDLE;
        end
        if (b == 8'h4C) begin
            return DEC_VICTORY;
        end else if (b == 8'h52) begin
            return DEC_READY;
        end else if (b == 8'h48) begin
            return DEC_HIT;
        end
        return DEC_IDLE;
    endfunction

    task automatic check_event(input decoder_state_e want, input decoder_state_e got);
        if (want !== got) begin
            $display("Fail event: expected 0x%h (%s) got 0x%h (%s)",
                     want, want.name(), got, got.name());
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int want, input int got);
        if (want != got) begin
            $display("Fail %s pulses: expected 0x%h got 0x%h", name, want, got);
            errors++;
        end
    endtask

    // all stimulus and checks happen 1 ns past the rising edge.
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_bit(input logic v);
        rxd = v;
        repeat (CLKS_PER_BIT) tick();
    endtask

    task automatic send_byte(input logic [7:0] b, input bit bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(!bad_stop);
        drive_bit(1'b1);
    endtask

    // queue the expected event, then put the byte on the line.
    task automatic send_msg(input logic [7:0] b);
        decoder_state_e kind;
        kind = expected_event(b, multiplayer);
        if (kind != DEC_IDLE) begin
            exp_q.push_back(kind);
        end
        send_byte(b, 1'b0);
    endtask

    task automatic wait_events_done();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < EVENT_TIMEOUT) begin
            tick();
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: %0d expected events never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (8) tick();
    endtask

    task automatic wait_frame_error(input int target);
        int n;
        n = 0;
        while (fe_count < target && n < EVENT_TIMEOUT) begin
            tick();
            n++;
        end
        if (fe_count < target) begin
            $display("timeout: frame_error pulse never came");
            errors++;
        end
    endtask

    task automatic begin_test();
        test_num++;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %0d %s: passed", test_num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: failed", test_num, name);
            tests_failed++;
        end
    endtask

    // monitor, sampled mid-cycle where registered outputs are stable.
    always @(negedge clk) begin
        if (!rst) begin
            if (victory) obs_q.push_back(DEC_VICTORY);
            if (opponent_ready) obs_q.push_back(DEC_READY);
            if (opponent_hit) obs_q.push_back(DEC_HIT);
            if (frame_error) fe_count++;
            if (rx_overflow) ovf_count++;
        end
    end

    always @(posedge clk) begin
        decoder_state_e got;
        while (obs_q.size() > 0) begin
            got = obs_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("unexpected %s event while none was expected", got.name());
                errors++;
            end else begin
                check_event(exp_q.pop_front(), got);
            end
        end
    end

    initial begin
        logic [7:0] b;
        int fe_before;
        int ovf_before;

        void'($urandom(42));
        clk = 1'b0;
        rst = 1'b1;
        rxd = 1'b1;
        multiplayer = 1'b0;
        errors = 0;
        fe_count = 0;
        ovf_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_num = 0;
        repeat (3) tick();
        rst = 1'b0;
        repeat (4) tick();

        begin_test();
        multiplayer = 1'b1;
        send_msg(8'h4C);
        send_msg(8'h52);
        send_msg(8'h48);
        wait_events_done();
        end_test("message codes");

        begin_test();
        for (int i = 0; i < 16; i++) begin
            if ($urandom_range(0, 2) == 0) begin
                case ($urandom_range(0, 2))
                    0: b = 8'h4C;
                    1: b = 8'h52;
                    default: b = 8'h48;
                endcase
            end else begin
                b = 8'($urandom_range(0, 255));
            end
            send_msg(b);
        end
        wait_events_done();
        end_test("mixed bytes");

        begin_test();
        multiplayer = 1'b0;
        send_msg(8'h4C);
        send_msg(8'h52);
        send_msg(8'h48);
        repeat (4 * CLKS_PER_BIT) tick();
        multiplayer = 1'b1;
        send_msg(8'h52);
        wait_events_done();
        end_test("single-player drain");

        begin_test();
        fe_before = fe_count;
        send_byte(8'h4C, 1'b1);
        wait_frame_error(fe_before + 1);
        send_msg(8'h48);
        wait_events_done();
        check_count("frame_error", fe_before + 1, fe_count);
        end_test("framing error");

        begin_test();
        ovf_before = ovf_count;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            send_msg((i % 2 == 0) ? 8'h48 : 8'h52);
        end
        wait_events_done();
        check_count("rx_overflow", ovf_before, ovf_count);
        end_test("burst without overflow");

        repeat (20) tick();
        if (obs_q.size() != 0 || exp_q.size() != 0) begin
            $display("events left over after the last test");
            errors++;
        end

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/game_link_pkg.sv
hw/uart_rx/uart_rx.sv
hw/char_fifo/char_fifo.sv
hw/opponent_msg_decoder/opponent_msg_decoder.sv
hw/link_rx_top.sv
verification/link_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= link_rx_tb
FILELIST  ?= files.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
